// ==== source/cu_control_pkg.sv ====
package cu_control_pkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int VERTEX_W   = 32;
	localparam int EDGE_W     = 32;
	localparam int ADDR_W     = 64;
	localparam int DATA_W     = 64;
	localparam int TAG_W      = 8;
	localparam int CU_ID_W    = 8;
	localparam int EDGE_INC_W = 8;

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	// routing destination carried in the id field
	typedef enum logic [CU_ID_W-1:0] {
		VERTEX_CONTROL_ID = 8'd0,
		ALGORITHM_ID
	} cu_dest_e;

	typedef enum logic [1:0] {
		CU_IDLE,
		CU_WAIT_WED,
		CU_RUNNING,
		CU_DONE
	} cu_state_e;

	//////////////////////////////////////////////////
	// bus lines
	//////////////////////////////////////////////////

	// 89 bits
	typedef struct packed {
		logic              valid;
		cu_dest_e          cu_id;
		logic [ADDR_W-1:0] address;
		logic [7:0]        size;
		logic [TAG_W-1:0]  tag;
	} cmd_line_t;

	// 17 bits
	typedef struct packed {
		logic               valid;
		logic [CU_ID_W-1:0] cu_id;
		logic [TAG_W-1:0]   tag;
	} response_line_t;

	// 73 bits
	typedef struct packed {
		logic               valid;
		logic [CU_ID_W-1:0] cu_id;
		logic [DATA_W-1:0]  data;
	} data_line_t;

	typedef struct packed {
		logic alfull;
		logic empty;
	} buffer_status_t;

	// 65-bit work descriptor
	typedef struct packed {
		logic                valid;
		logic [VERTEX_W-1:0] num_vertices;
		logic [EDGE_W-1:0]   num_edges;
	} wed_t;

	typedef struct packed {
		logic [VERTEX_W-1:0] vertex_count;
		logic [EDGE_W-1:0]   edge_count;
	} cu_return_t;

endpackage

// ==== source/cu_run_fsm.sv ====
`timescale 1ns/1ps

module cu_run_fsm (
	input  logic        clock,
	input  logic        rstn,
	input  logic        enabled,
	input  logic [63:0] config_latched,
	input  logic        wed_valid,
	input  logic        complete,
	output logic        running,
	output logic        start,
	output logic        cu_done
);

	cu_control_pkg::cu_state_e state;
	cu_control_pkg::cu_state_e state_next;

	//////////////////////////////////////////////////
	// run sequence
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			cu_control_pkg::CU_IDLE: begin
				// any nonzero configuration arms the unit
				if (|config_latched) begin
					state_next = cu_control_pkg::CU_WAIT_WED;
				end
			end
			cu_control_pkg::CU_WAIT_WED: begin
				if (wed_valid) begin
					state_next = cu_control_pkg::CU_RUNNING;
				end
			end
			cu_control_pkg::CU_RUNNING: begin
				if (complete) begin
					state_next = cu_control_pkg::CU_DONE;
				end
			end
			cu_control_pkg::CU_DONE: begin
				// hold done until the host drops enable
				if (!enabled) begin
					state_next = cu_control_pkg::CU_IDLE;
				end
			end
			default: begin
				state_next = cu_control_pkg::CU_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= cu_control_pkg::CU_IDLE;
			start <= 1'b0;
		end else begin
			state <= state_next;
			// high in the first running cycle only
			start <= (state == cu_control_pkg::CU_WAIT_WED) && wed_valid;
		end
	end

	assign running = (state == cu_control_pkg::CU_RUNNING);
	assign cu_done = (state == cu_control_pkg::CU_DONE);

endmodule

// ==== source/cu_job_counter.sv ====
`timescale 1ns/1ps

module cu_job_counter (
	input  logic                                    clock,
	input  logic                                    rstn,
	input  logic                                    running,
	input  logic                                    start,
	input  logic                                    vertex_done,
	input  logic                                    vertex_filtered,
	input  logic                                    edge_done,
	input  logic [cu_control_pkg::EDGE_INC_W-1:0]   edge_increment,
	input  cu_control_pkg::wed_t                    wed_totals,
	output logic                                    complete,
	output cu_control_pkg::cu_return_t              cu_return
);

	logic [1:0]                          vertex_inc;
	logic [cu_control_pkg::EDGE_W-1:0]   edge_inc;
	logic [cu_control_pkg::VERTEX_W-1:0] vertex_total;
	logic [cu_control_pkg::EDGE_W-1:0]   edge_total;

	// a filtered vertex counts as finished too
	assign vertex_inc = 2'(vertex_done) + 2'(vertex_filtered);
	assign edge_inc   = edge_done ? cu_control_pkg::EDGE_W'(edge_increment) : '0;

	// totals frozen for the whole run
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_total <= '0;
			edge_total   <= '0;
		end else if (start) begin
			vertex_total <= wed_totals.num_vertices;
			edge_total   <= wed_totals.num_edges;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
		end else if (start) begin
			// counts restart from zero and pulses in this cycle still count
			cu_return.vertex_count <= cu_control_pkg::VERTEX_W'(vertex_inc);
			cu_return.edge_count   <= edge_inc;
		end else if (running) begin
			cu_return.vertex_count <= cu_return.vertex_count
				+ cu_control_pkg::VERTEX_W'(vertex_inc);
			cu_return.edge_count   <= cu_return.edge_count + edge_inc;
		end
	end

	// totals and counts are stale during the start cycle
	assign complete = running && !start
		&& (cu_return.vertex_count == vertex_total)
		&& (cu_return.edge_count == edge_total);

endmodule

// ==== source/cu_response_router.sv ====
`timescale 1ns/1ps

module cu_response_router (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled,
	input  logic [63:0]                    cu_configure,
	input  cu_control_pkg::wed_t           wed,
	input  cu_control_pkg::response_line_t read_response,
	input  cu_control_pkg::response_line_t write_response,
	input  cu_control_pkg::data_line_t     read_data,
	input  cu_control_pkg::buffer_status_t read_buffer_status,
	input  cu_control_pkg::buffer_status_t write_buffer_status,
	output logic [63:0]                    config_latched,
	output logic [63:0]                    cu_status,
	output cu_control_pkg::wed_t           wed_latched,
	output cu_control_pkg::response_line_t vertex_response,
	output cu_control_pkg::response_line_t algorithm_response,
	output cu_control_pkg::response_line_t algorithm_write_response,
	output cu_control_pkg::data_line_t     vertex_data,
	output cu_control_pkg::data_line_t     algorithm_data,
	output cu_control_pkg::buffer_status_t read_status_latched,
	output cu_control_pkg::buffer_status_t write_status_latched
);

	cu_control_pkg::response_line_t read_response_q;
	cu_control_pkg::response_line_t write_response_q;
	cu_control_pkg::data_line_t     read_data_q;

	function automatic logic to_vertex(input logic [cu_control_pkg::CU_ID_W-1:0] id);
		return cu_control_pkg::cu_dest_e'(id) == cu_control_pkg::VERTEX_CONTROL_ID;
	endfunction

	//////////////////////////////////////////////////
	// enable gated input stage
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_response_q      <= '0;
			write_response_q     <= '0;
			read_data_q          <= '0;
			wed_latched          <= '0;
			config_latched       <= '0;
			cu_status            <= '0;
			read_status_latched  <= 2'b01;
			write_status_latched <= 2'b01;
		end else begin
			if (enabled) begin
				read_response_q      <= read_response;
				write_response_q     <= write_response;
				read_data_q          <= read_data;
				read_status_latched  <= read_buffer_status;
				write_status_latched <= write_buffer_status;
			end else begin
				// beats seen while disabled are lost
				read_response_q.valid  <= 1'b0;
				write_response_q.valid <= 1'b0;
				read_data_q.valid      <= 1'b0;
			end
			// descriptor totals stay after the valid strobe
			if (enabled && wed.valid) begin
				wed_latched <= wed;
			end else begin
				wed_latched.valid <= 1'b0;
			end
			if (enabled && (|cu_configure)) begin
				config_latched <= cu_configure;
			end
			cu_status <= config_latched;
		end
	end

	//////////////////////////////////////////////////
	// destination decode
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_response          <= '0;
			algorithm_response       <= '0;
			algorithm_write_response <= '0;
			vertex_data              <= '0;
			algorithm_data           <= '0;
		end else begin
			vertex_response          <= read_response_q;
			algorithm_response       <= read_response_q;
			vertex_response.valid    <= read_response_q.valid && to_vertex(read_response_q.cu_id);
			algorithm_response.valid <= read_response_q.valid && !to_vertex(read_response_q.cu_id);
			vertex_data              <= read_data_q;
			algorithm_data           <= read_data_q;
			vertex_data.valid        <= read_data_q.valid && to_vertex(read_data_q.cu_id);
			algorithm_data.valid     <= read_data_q.valid && !to_vertex(read_data_q.cu_id);
			// write responses only ever belong to the algorithm side
			algorithm_write_response <= write_response_q;
		end
	end

endmodule

// ==== source/cu_command_port.sv ====
`timescale 1ns/1ps

module cu_command_port #(
	parameter int NUM_READ_REQUESTS = 2
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           running,
	input  cu_control_pkg::buffer_status_t read_status_latched,
	input  cu_control_pkg::buffer_status_t write_status_latched,
	input  logic [NUM_READ_REQUESTS-1:0]   read_request,
	input  cu_control_pkg::cmd_line_t      read_command [0:NUM_READ_REQUESTS-1],
	input  logic                           write_request,
	input  cu_control_pkg::cmd_line_t      write_command,
	output logic [NUM_READ_REQUESTS-1:0]   read_grant,
	output cu_control_pkg::cmd_line_t      read_out,
	output cu_control_pkg::cmd_line_t      write_out,
	output logic                           write_grant
);

	localparam int PTR_W = (NUM_READ_REQUESTS > 1) ? $clog2(NUM_READ_REQUESTS) : 1;

	logic [PTR_W-1:0]             last_winner;
	logic [PTR_W-1:0]             pick_idx;
	logic                         pick_valid;
	logic [NUM_READ_REQUESTS-1:0] eligible;
	logic                         read_open;
	cu_control_pkg::cmd_line_t    write_q;

	//////////////////////////////////////////////////
	// read round robin
	//////////////////////////////////////////////////

	// a requester sees its grant one cycle late, so skip it for that cycle
	assign eligible  = read_request & ~read_grant;
	assign read_open = running && !read_status_latched.alfull;

	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_idx   = last_winner;
		// search starts one past the last winner
		for (int off = 1; off <= NUM_READ_REQUESTS; off++) begin
			idx = (int'(last_winner) + off) % NUM_READ_REQUESTS;
			if (!pick_valid && eligible[idx]) begin
				pick_valid = 1'b1;
				pick_idx   = PTR_W'(idx);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_grant  <= '0;
			last_winner <= PTR_W'(NUM_READ_REQUESTS - 1);
			read_out    <= '0;
		end else begin
			read_grant     <= '0;
			read_out       <= read_command[pick_idx];
			read_out.valid <= read_open && pick_valid;
			if (read_open && pick_valid) begin
				read_grant[pick_idx] <= 1'b1;
				last_winner          <= pick_idx;
			end
		end
	end

	//////////////////////////////////////////////////
	// write grant and command
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_grant <= 1'b0;
			write_q     <= '0;
		end else begin
			write_grant   <= write_request && running && !write_status_latched.alfull;
			write_q       <= write_command;
			write_q.valid <= write_command.valid && running;
		end
	end

	// drop the command at once when the run ends
	always_comb begin
		write_out       = write_q;
		write_out.valid = write_q.valid && running;
	end

endmodule

// ==== source/cu_control_top.sv ====
`timescale 1ns/1ps

module cu_control_top #(
	parameter int NUM_READ_REQUESTS = 2
) (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  enabled,
	input  logic [63:0]                           cu_configure,
	input  cu_control_pkg::wed_t                  wed,
	input  cu_control_pkg::response_line_t        read_response,
	input  cu_control_pkg::data_line_t            read_data,
	input  cu_control_pkg::response_line_t        write_response,
	input  cu_control_pkg::buffer_status_t        read_buffer_status,
	input  cu_control_pkg::buffer_status_t        write_buffer_status,
	input  logic [NUM_READ_REQUESTS-1:0]          read_request,
	input  cu_control_pkg::cmd_line_t             read_command [0:NUM_READ_REQUESTS-1],
	input  logic                                  write_request,
	input  cu_control_pkg::cmd_line_t             write_command,
	input  logic                                  vertex_done,
	input  logic                                  vertex_filtered,
	input  logic                                  edge_done,
	input  logic [cu_control_pkg::EDGE_INC_W-1:0] edge_increment,
	output logic [63:0]                           cu_status,
	output cu_control_pkg::cu_return_t            cu_return,
	output logic                                  cu_done,
	output cu_control_pkg::response_line_t        vertex_response,
	output cu_control_pkg::response_line_t        algorithm_response,
	output cu_control_pkg::response_line_t        algorithm_write_response,
	output cu_control_pkg::data_line_t            vertex_data,
	output cu_control_pkg::data_line_t            algorithm_data,
	output logic [NUM_READ_REQUESTS-1:0]          read_grant,
	output cu_control_pkg::cmd_line_t             read_out,
	output logic                                  write_grant,
	output cu_control_pkg::cmd_line_t             write_out
);

	logic [63:0]                    config_latched;
	cu_control_pkg::wed_t           wed_latched;
	cu_control_pkg::buffer_status_t read_status_latched;
	cu_control_pkg::buffer_status_t write_status_latched;
	logic                           running;
	logic                           start;
	logic                           complete;

	cu_response_router router_i (
		.clock, .rstn, .enabled, .cu_configure, .wed,
		.read_response, .write_response, .read_data,
		.read_buffer_status, .write_buffer_status,
		.config_latched, .cu_status, .wed_latched,
		.vertex_response, .algorithm_response, .algorithm_write_response,
		.vertex_data, .algorithm_data,
		.read_status_latched, .write_status_latched
	);

	cu_run_fsm run_fsm_i (
		.clock, .rstn, .enabled, .config_latched,
		.wed_valid (wed_latched.valid),
		.complete, .running, .start, .cu_done
	);

	cu_job_counter job_counter_i (
		.clock, .rstn, .running, .start,
		.vertex_done, .vertex_filtered, .edge_done, .edge_increment,
		.wed_totals (wed_latched),
		.complete, .cu_return
	);

	cu_command_port #(
		.NUM_READ_REQUESTS (NUM_READ_REQUESTS)
	) command_port_i (
		.clock, .rstn, .running,
		.read_status_latched, .write_status_latched,
		.read_request, .read_command, .write_request, .write_command,
		.read_grant, .read_out, .write_out, .write_grant
	);

endmodule

// ==== testbench/cu_control_properties.sv ====
`timescale 1ns/1ps

module cu_control_properties #(
	parameter int NUM_READ_REQUESTS = 2
) (
	input logic                           clock,
	input logic                           rstn,
	input logic                           enabled,
	input logic                           running,
	input logic [63:0]                    cu_configure,
	input logic [63:0]                    cu_status,
	input cu_control_pkg::response_line_t read_response,
	input cu_control_pkg::response_line_t write_response,
	input cu_control_pkg::data_line_t     read_data,
	input cu_control_pkg::response_line_t vertex_response,
	input cu_control_pkg::response_line_t algorithm_response,
	input cu_control_pkg::response_line_t algorithm_write_response,
	input cu_control_pkg::data_line_t     vertex_data,
	input cu_control_pkg::data_line_t     algorithm_data,
	input cu_control_pkg::buffer_status_t read_status_latched,
	input cu_control_pkg::buffer_status_t write_status_latched,
	input logic [NUM_READ_REQUESTS-1:0]   read_request,
	input logic                           write_request,
	input cu_control_pkg::cmd_line_t      write_command,
	input logic                           write_grant,
	input logic [NUM_READ_REQUESTS-1:0]   read_grant,
	input cu_control_pkg::cmd_line_t      read_out,
	input cu_control_pkg::cmd_line_t      write_out,
	input logic                           cu_done
);

	int error_count = 0;

	//////////////////////////////////////////////////
	// routing two cycles after the port
	//////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstn)
		vertex_response.valid == $past(enabled && read_response.valid
		&& read_response.cu_id == cu_control_pkg::VERTEX_CONTROL_ID, 2))
	else begin
		$error("vertex_response valid on the wrong cycle or side");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		algorithm_response.valid == $past(enabled && read_response.valid
		&& read_response.cu_id != cu_control_pkg::VERTEX_CONTROL_ID, 2))
	else begin
		$error("algorithm_response valid on the wrong cycle or side");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		vertex_data.valid == $past(enabled && read_data.valid
		&& read_data.cu_id == cu_control_pkg::VERTEX_CONTROL_ID, 2))
	else begin
		$error("vertex_data valid on the wrong cycle or side");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		algorithm_data.valid == $past(enabled && read_data.valid
		&& read_data.cu_id != cu_control_pkg::VERTEX_CONTROL_ID, 2))
	else begin
		$error("algorithm_data valid on the wrong cycle or side");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		algorithm_write_response.valid == $past(enabled && write_response.valid, 2))
	else begin
		$error("write response routed on the wrong cycle");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		(enabled && cu_configure != '0) |-> ##2 (cu_status == $past(cu_configure, 2)))
	else begin
		$error("configuration word missing from cu_status");
		error_count++;
	end

	//////////////////////////////////////////////////
	// command port
	//////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstn)
		write_grant == $past(write_request && running && !write_status_latched.alfull))
	else begin
		$error("write_grant broke the grant rule");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		$past(read_status_latched.alfull || !running) |-> (read_grant == '0 && !read_out.valid))
	else begin
		$error("read command issued under back-pressure");
		error_count++;
	end

	// with every requester waiting and no back-pressure someone must win
	assert property (@(posedge clock) disable iff (!rstn)
		(running && !read_status_latched.alfull && (&read_request)) |=> (read_grant != '0))
	else begin
		$error("no read grant although requests were pending");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		$onehot0(read_grant) && ((read_grant != '0) == read_out.valid))
	else begin
		$error("read_grant and read_out valid disagree");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn) !running |-> !write_out.valid)
	else begin
		$error("write_out valid outside a run");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn)
		(running && $past(running)) |-> (write_out.valid == $past(write_command.valid)))
	else begin
		$error("write_out valid does not follow write_command");
		error_count++;
	end

	assert property (@(posedge clock) disable iff (!rstn) $fell(cu_done) |-> !$past(enabled))
	else begin
		$error("cu_done fell while enabled was high");
		error_count++;
	end

endmodule

bind cu_control_top cu_control_properties #(
	.NUM_READ_REQUESTS (NUM_READ_REQUESTS)
) props_i (.*);

// ==== testbench/tb_cu_control.sv ====
`timescale 1ns/1ps

module tb_cu_control;

	localparam int NUM_READ_REQUESTS = 2;
	localparam int PERIOD            = 20;
	localparam int ROUTE_CYCLES      = 60;
	localparam int MAX_VERTICES      = 40;
	localparam int MAX_EDGES         = 120;
	// reset, idle, configuration, routing, descriptor, pulses, drain
	localparam int TEST_CYCLES = 3 + 8 + 14 + ROUTE_CYCLES + 5 + MAX_VERTICES + MAX_EDGES + 20;
	localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * PERIOD;

	logic                           clock = 1'b0;
	logic                           rstn;
	logic                           enabled;
	logic [63:0]                    cu_configure;
	cu_control_pkg::wed_t           wed;
	cu_control_pkg::response_line_t read_response;
	cu_control_pkg::data_line_t     read_data;
	cu_control_pkg::response_line_t write_response;
	cu_control_pkg::buffer_status_t read_buffer_status = '0;
	cu_control_pkg::buffer_status_t write_buffer_status = '0;
	logic [NUM_READ_REQUESTS-1:0]   read_request = '0;
	cu_control_pkg::cmd_line_t      read_command [0:NUM_READ_REQUESTS-1] = '{default: '0};
	logic                           write_request = 1'b0;
	cu_control_pkg::cmd_line_t      write_command = '0;
	logic                           vertex_done;
	logic                           vertex_filtered;
	logic                           edge_done;
	logic [7:0]                     edge_increment;
	logic [63:0]                    cu_status;
	cu_control_pkg::cu_return_t     cu_return;
	logic                           cu_done;
	cu_control_pkg::response_line_t vertex_response;
	cu_control_pkg::response_line_t algorithm_response;
	cu_control_pkg::response_line_t algorithm_write_response;
	cu_control_pkg::data_line_t     vertex_data;
	cu_control_pkg::data_line_t     algorithm_data;
	logic [NUM_READ_REQUESTS-1:0]   read_grant;
	cu_control_pkg::cmd_line_t      read_out;
	logic                           write_grant;
	cu_control_pkg::cmd_line_t      write_out;

	// stimulus state and reference models
	logic                           config_sent;
	logic                           requesters_on;
	logic                           traffic_on;
	logic [31:0]                    vertices_sent;
	logic [31:0]                    edges_sent;
	logic [31:0]                    total_vertices;
	logic [31:0]                    total_edges;
	logic [31:0]                    vertices_sent_d1;
	logic [31:0]                    edges_sent_d1;
	logic [63:0]                    config_model;
	logic [63:0]                    status_model;
	logic [NUM_READ_REQUESTS-1:0]   last_grant;
	cu_control_pkg::response_line_t resp_d1;
	cu_control_pkg::response_line_t resp_d2;
	cu_control_pkg::response_line_t wresp_d1;
	cu_control_pkg::response_line_t wresp_d2;
	cu_control_pkg::data_line_t     data_d1;
	cu_control_pkg::data_line_t     data_d2;
	cu_control_pkg::cmd_line_t      read_cmd_d1 [0:NUM_READ_REQUESTS-1];
	cu_control_pkg::cmd_line_t      write_cmd_d1;

	cu_control_top #(
		.NUM_READ_REQUESTS (NUM_READ_REQUESTS)
	) dut_i (.*);

	always #(PERIOD / 2) clock = ~clock;

	task automatic abort_run(input string text);
		$display("%s", text);
		$display("Test failed");
		$fatal(1, "%s", text);
	endtask

	task automatic mismatch(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		$display("FAIL %s expected %0h actual %0h", name, expected, actual);
		$display("Test failed");
		$fatal(1, "%s mismatch", name);
	endtask

	function automatic cu_control_pkg::cmd_line_t random_command();
		cu_control_pkg::cmd_line_t cmd;
		cmd.valid   = 1'b1;
		cmd.cu_id   = cu_control_pkg::cu_dest_e'($urandom_range(0, 1));
		cmd.address = {$urandom, $urandom};
		cmd.size    = 8'($urandom);
		cmd.tag     = 8'($urandom);
		return cmd;
	endfunction

	function automatic logic [7:0] random_id();
		// about half of the beats go to the vertex side
		if ($urandom % 2 == 0) begin
			return 8'd0;
		end
		return 8'($urandom_range(1, 255));
	endfunction

	//////////////////////////////////////////////////
	// reference models
	//////////////////////////////////////////////////

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			resp_d1          <= '0;
			resp_d2          <= '0;
			wresp_d1         <= '0;
			wresp_d2         <= '0;
			data_d1          <= '0;
			data_d2          <= '0;
			read_cmd_d1      <= '{default: '0};
			write_cmd_d1     <= '0;
			vertices_sent_d1 <= '0;
			edges_sent_d1    <= '0;
			last_grant       <= '0;
			config_model     <= '0;
			status_model     <= '0;
		end else begin
			resp_d1          <= read_response;
			resp_d2          <= resp_d1;
			wresp_d1         <= write_response;
			wresp_d2         <= wresp_d1;
			data_d1          <= read_data;
			data_d2          <= data_d1;
			read_cmd_d1      <= read_command;
			write_cmd_d1     <= write_command;
			vertices_sent_d1 <= vertices_sent;
			edges_sent_d1    <= edges_sent;
			if (read_grant != '0) begin
				last_grant <= read_grant;
			end
			// zero words never replace the configuration
			if (enabled && cu_configure != '0) begin
				config_model <= cu_configure;
			end
			status_model <= config_model;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	assert property (@(posedge clock) disable iff (!rstn)
		!config_sent |-> ({vertex_response.valid, algorithm_response.valid,
		algorithm_write_response.valid, vertex_data.valid, algorithm_data.valid,
		read_grant, write_grant, read_out.valid, write_out.valid, cu_done} == '0
		&& cu_status == '0 && cu_return == '0))
	else abort_run("outputs left their reset values before the configuration was written");

	assert property (@(posedge clock) disable iff (!rstn)
		vertex_response.valid |-> vertex_response == resp_d2)
	else mismatch("vertex_response", $sampled(resp_d2), $sampled(vertex_response));

	assert property (@(posedge clock) disable iff (!rstn)
		algorithm_response.valid |-> algorithm_response == resp_d2)
	else mismatch("algorithm_response", $sampled(resp_d2), $sampled(algorithm_response));

	assert property (@(posedge clock) disable iff (!rstn)
		vertex_data.valid |-> vertex_data == data_d2)
	else mismatch("vertex_data", $sampled(data_d2), $sampled(vertex_data));

	assert property (@(posedge clock) disable iff (!rstn)
		algorithm_data.valid |-> algorithm_data == data_d2)
	else mismatch("algorithm_data", $sampled(data_d2), $sampled(algorithm_data));

	assert property (@(posedge clock) disable iff (!rstn)
		algorithm_write_response.valid |-> algorithm_write_response == wresp_d2)
	else mismatch("write_response", $sampled(wresp_d2), $sampled(algorithm_write_response));

	assert property (@(posedge clock) disable iff (!rstn) cu_status == status_model)
	else mismatch("cu_status", $sampled(status_model), $sampled(cu_status));

	assert property (@(posedge clock) disable iff (!rstn)
		read_grant[0] |-> read_out == read_cmd_d1[0])
	else mismatch("read_out_0", $sampled(read_cmd_d1[0]), $sampled(read_out));

	assert property (@(posedge clock) disable iff (!rstn)
		read_grant[1] |-> read_out == read_cmd_d1[1])
	else mismatch("read_out_1", $sampled(read_cmd_d1[1]), $sampled(read_out));

	// both requesters stay busy, so the winners take turns
	assert property (@(posedge clock) disable iff (!rstn)
		(read_grant != '0 && last_grant != '0) |-> read_grant == ~last_grant)
	else mismatch("read_grant_order", $sampled(~last_grant), $sampled(read_grant));

	assert property (@(posedge clock) disable iff (!rstn)
		write_out.valid |-> write_out == write_cmd_d1)
	else mismatch("write_out", $sampled(write_cmd_d1), $sampled(write_out));

	assert property (@(posedge clock) disable iff (!rstn)
		cu_return == {vertices_sent_d1, edges_sent_d1})
	else mismatch("cu_return", $sampled({vertices_sent_d1, edges_sent_d1}),
		$sampled(cu_return));

	assert property (@(posedge clock) disable iff (!rstn)
		cu_done |-> cu_return == {total_vertices, total_edges})
	else mismatch("done_totals", $sampled({total_vertices, total_edges}),
		$sampled(cu_return));

	always @(posedge clock) begin
		if (dut_i.props_i.error_count != 0) begin
			abort_run("a port timing assertion failed");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the run finished");
	end

	//////////////////////////////////////////////////
	// background requesters and buffer traffic
	//////////////////////////////////////////////////

	always @(posedge clock) begin
		for (int i = 0; i < NUM_READ_REQUESTS; i++) begin
			if (read_grant[i]) begin
				read_request[i] <= 1'b0;
			end else if (requesters_on && !read_request[i]) begin
				read_request[i] <= 1'b1;
				read_command[i] <= random_command();
			end
		end
	end

	always @(posedge clock) begin
		if (traffic_on) begin
			read_buffer_status  <= {($urandom % 4 == 0), 1'b0};
			write_buffer_status <= {($urandom % 4 == 0), 1'b0};
			write_request       <= ($urandom % 2 == 0);
			write_command       <= random_command();
			write_command.valid <= ($urandom % 2 == 0);
		end else begin
			read_buffer_status  <= '0;
			write_buffer_status <= '0;
			write_request       <= 1'b0;
			write_command       <= '0;
		end
	end

	//////////////////////////////////////////////////
	// test phases
	//////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
	endtask

	task automatic configure_unit();
		@(posedge clock);
		cu_configure <= {$urandom, $urandom} | 64'h1;
		config_sent  <= 1'b1;
		@(posedge clock);
		cu_configure <= '0;
		wait_cycles(4);
		cu_configure <= {$urandom, $urandom} | 64'h100;
		@(posedge clock);
		cu_configure <= '0;
		wait_cycles(4);
	endtask

	task automatic send_beats();
		traffic_on <= 1'b1;
		repeat (ROUTE_CYCLES) begin
			@(posedge clock);
			enabled              <= ($urandom % 4 != 0);
			read_response.valid  <= ($urandom % 3 != 0);
			read_response.cu_id  <= random_id();
			read_response.tag    <= 8'($urandom);
			write_response.valid <= ($urandom % 3 != 0);
			write_response.cu_id <= random_id();
			write_response.tag   <= 8'($urandom);
			read_data.valid      <= ($urandom % 3 != 0);
			read_data.cu_id      <= random_id();
			read_data.data       <= {$urandom, $urandom};
		end
		@(posedge clock);
		enabled        <= 1'b1;
		read_response  <= '0;
		write_response <= '0;
		read_data      <= '0;
	endtask

	task automatic run_job();
		int   remaining_v;
		int   remaining_e;
		int   inc;
		logic vd;
		logic vf;
		logic ed;
		remaining_v = 10 + $urandom % (MAX_VERTICES - 10);
		remaining_e = 20 + $urandom % (MAX_EDGES - 20);
		@(posedge clock);
		total_vertices <= remaining_v;
		total_edges    <= remaining_e;
		wed            <= '{valid: 1'b1, num_vertices: remaining_v, num_edges: remaining_e};
		requesters_on  <= 1'b1;
		@(posedge clock);
		wed.valid <= 1'b0;
		// descriptor latch, then the first running cycle
		wait_cycles(2);
		while (remaining_v > 0 || remaining_e > 0) begin
			@(posedge clock);
			vd = (remaining_v > 0) && ($urandom % 2 == 0);
			vf = (remaining_v > int'(vd)) && ($urandom % 3 == 0);
			ed = (remaining_e > 0) && ($urandom % 2 == 0);
			if (!vd && !vf && !ed) begin
				if (remaining_v > 0) begin
					vd = 1'b1;
				end else begin
					ed = 1'b1;
				end
			end
			inc = 1 + $urandom % 8;
			if (inc > remaining_e) begin
				inc = remaining_e;
			end
			vertex_done     <= vd;
			vertex_filtered <= vf;
			edge_done       <= ed;
			edge_increment  <= ed ? 8'(inc) : 8'($urandom);
			vertices_sent   <= vertices_sent + int'(vd) + int'(vf);
			edges_sent      <= edges_sent + (ed ? inc : 0);
			remaining_v     = remaining_v - int'(vd) - int'(vf);
			remaining_e     = remaining_e - (ed ? inc : 0);
		end
		@(posedge clock);
		vertex_done     <= 1'b0;
		vertex_filtered <= 1'b0;
		edge_done       <= 1'b0;
		while (!cu_done) @(posedge clock);
		requesters_on <= 1'b0;
		traffic_on    <= 1'b0;
		wait_cycles(3);
		enabled <= 1'b0;
		while (cu_done) @(posedge clock);
		wait_cycles(3);
	endtask

	initial begin
		void'($urandom(32'hd504));
		rstn            = 1'b0;
		enabled         = 1'b0;
		cu_configure    = '0;
		wed             = '0;
		read_response   = '0;
		read_data       = '0;
		write_response  = '0;
		vertex_done     = 1'b0;
		vertex_filtered = 1'b0;
		edge_done       = 1'b0;
		edge_increment  = '0;
		config_sent     = 1'b0;
		requesters_on   = 1'b0;
		traffic_on      = 1'b0;
		vertices_sent   = '0;
		edges_sent      = '0;
		total_vertices  = '0;
		total_edges     = '0;
		wait_cycles(3);
		rstn    <= 1'b1;
		enabled <= 1'b1;
		wait_cycles(8);
		configure_unit();
		send_beats();
		run_job();
		if (dut_i.props_i.error_count != 0) begin
			$display("Test failed");
			$fatal(1, "port timing assertions reported errors");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

// ==== sources.f ====
source/cu_control_pkg.sv
source/cu_run_fsm.sv
source/cu_job_counter.sv
source/cu_response_router.sv
source/cu_command_port.sv
source/cu_control_top.sv
testbench/cu_control_properties.sv
testbench/tb_cu_control.sv
